/* source/parser_pkg.sv */
// beat width fixed at 8 bytes; byte offsets assume one vlan tag at most and a 20 byte ipv4 header
package parser_pkg;

    // stream geometry
    localparam int DATA_BYTES = 8;

    typedef logic [2:0] beat_idx_t;

    // first beat past the last header byte (byte 41 sits in beat 5)
    localparam beat_idx_t MAX_BEAT = 3'd6;

    // byte k of a beat is data[8k+7:8k], first wire byte lowest
    typedef struct packed {
        logic [8*DATA_BYTES-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } beat_t;

    // captured header fields, multi-byte values big-endian
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
        logic [15:0] inner_type;
        logic [7:0]  ip_proto;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } hdr_fields_t;

    typedef struct packed {
        logic vlan;
        logic arp;
        logic ipv4;
        logic tcp;
        logic udp;
    } parse_flags_t;

    typedef enum logic [3:0] {
        PT_NONE = 4'h0,
        PT_IPV4 = 4'h1,
        PT_VLV4 = 4'h2
    } pkt_type_t;

    // ethertype and ip protocol codes
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [15:0] ETH_TYPE_ARP  = 16'h0806;
    localparam logic [15:0] ETH_TYPE_VLAN = 16'h8100;
    localparam logic [7:0]  IP_PROTO_TCP  = 8'd6;
    localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;

    // byte offsets in an untagged frame
    localparam int OFF_DST_MAC    = 0;
    localparam int OFF_SRC_MAC    = 6;
    localparam int OFF_ETH_TYPE   = 12;
    localparam int OFF_INNER_TYPE = 16;
    localparam int OFF_IP_PROTO   = 23;
    localparam int OFF_SRC_IP     = 26;
    localparam int OFF_DST_IP     = 30;
    localparam int OFF_SRC_PORT   = 34;
    localparam int OFF_DST_PORT   = 36;

    // added to offsets from the ip protocol byte on when tagged
    localparam int VLAN_SHIFT = 4;

endpackage

/* source/stream_stage.sv */
// single register slice, one cycle latency; beat index saturates and only resets on last
`timescale 1ns/1ps

module stream_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  parser_pkg::beat_t    s_beat,
    input  logic                 s_valid,
    output logic                 s_ready,
    output parser_pkg::beat_t    m_beat,
    output logic                 m_valid,
    input  logic                 m_ready,
    output logic                 accept,
    output parser_pkg::beat_idx_t beat_idx
);

    parser_pkg::beat_idx_t idx;

    // register free or draining this cycle
    assign s_ready  = !m_valid || m_ready;
    assign accept   = s_valid && s_ready;
    assign beat_idx = idx;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (accept) begin
            m_valid <= 1'b1;
        end else if (m_ready) begin
            m_valid <= 1'b0;
        end
    end

    // payload register
    always_ff @(posedge clk) begin
        if (accept) begin
            m_beat <= s_beat;
        end
    end

    // position of the next beat within its frame
    always_ff @(posedge clk) begin
        if (rst) begin
            idx <= '0;
        end else if (accept) begin
            if (s_beat.last) begin
                idx <= '0;
            end else if (idx != parser_pkg::MAX_BEAT) begin
                idx <= idx + 3'd1;
            end
        end
    end

endmodule

/* source/header_capture.sv */
// fixed offsets only: no ipv4 options, one vlan tag; keep is ignored, so short frames leave zeros
`timescale 1ns/1ps

module header_capture (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    accept,
    input  parser_pkg::beat_t       beat,
    input  parser_pkg::beat_idx_t   beat_idx,
    input  logic                    vlan,
    input  logic                    ipv4,
    input  logic                    l4,
    output parser_pkg::hdr_fields_t fields
);

    parser_pkg::hdr_fields_t nxt;

    // true when absolute byte pos lies in [off, off+len)
    function automatic logic in_field(input logic [5:0] pos, input int off, input int len);
        return (int'(pos) >= off) && (int'(pos) < off + len);
    endfunction

    // bit position of byte pos inside a big-endian field
    function automatic int lsb(input logic [5:0] pos, input int off, input int len);
        return 8 * (off + len - 1 - int'(pos));
    endfunction

    always_comb begin
        logic [5:0] pos;
        logic [5:0] rel;
        logic [7:0] b;

        // first beat of a frame starts from a clean slate
        nxt = (beat_idx == '0) ? '0 : fields;
        pos = '0;
        rel = '0;
        b   = '0;

        for (int lane = 0; lane < parser_pkg::DATA_BYTES; lane++) begin
            pos = 6'(int'(beat_idx) * parser_pkg::DATA_BYTES + lane);
            // ip layer shifted past the tag
            rel = vlan ? pos - 6'(parser_pkg::VLAN_SHIFT) : pos;
            b   = beat.data[8*lane +: 8];

            if (in_field(pos, parser_pkg::OFF_DST_MAC, 6)) begin
                nxt.dst_mac[lsb(pos, parser_pkg::OFF_DST_MAC, 6) +: 8] = b;
            end
            if (in_field(pos, parser_pkg::OFF_SRC_MAC, 6)) begin
                nxt.src_mac[lsb(pos, parser_pkg::OFF_SRC_MAC, 6) +: 8] = b;
            end
            if (in_field(pos, parser_pkg::OFF_ETH_TYPE, 2)) begin
                nxt.eth_type[lsb(pos, parser_pkg::OFF_ETH_TYPE, 2) +: 8] = b;
            end
            if (vlan && in_field(pos, parser_pkg::OFF_INNER_TYPE, 2)) begin
                nxt.inner_type[lsb(pos, parser_pkg::OFF_INNER_TYPE, 2) +: 8] = b;
            end

            // protocol byte taken always, classifier qualifies it with ipv4
            if (in_field(rel, parser_pkg::OFF_IP_PROTO, 1)) begin
                nxt.ip_proto = b;
            end
            if (ipv4 && in_field(rel, parser_pkg::OFF_SRC_IP, 4)) begin
                nxt.src_ip[lsb(rel, parser_pkg::OFF_SRC_IP, 4) +: 8] = b;
            end
            if (ipv4 && in_field(rel, parser_pkg::OFF_DST_IP, 4)) begin
                nxt.dst_ip[lsb(rel, parser_pkg::OFF_DST_IP, 4) +: 8] = b;
            end
            if (l4 && in_field(rel, parser_pkg::OFF_SRC_PORT, 2)) begin
                nxt.src_port[lsb(rel, parser_pkg::OFF_SRC_PORT, 2) +: 8] = b;
            end
            if (l4 && in_field(rel, parser_pkg::OFF_DST_PORT, 2)) begin
                nxt.dst_port[lsb(rel, parser_pkg::OFF_DST_PORT, 2) +: 8] = b;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fields <= '0;
        end else if (accept) begin
            fields <= nxt;
        end
    end

endmodule

/* source/frame_classifier.sv */
// purely combinational decode of registered fields; only ipv4 tcp and udp get a packet type
`timescale 1ns/1ps

module frame_classifier (
    input  parser_pkg::hdr_fields_t  fields,
    output parser_pkg::parse_flags_t flags,
    output parser_pkg::pkt_type_t    pkt_type
);

    logic        vlan;
    logic        ipv4;
    logic        l4;
    logic [15:0] eff_type;

    assign vlan = (fields.eth_type == parser_pkg::ETH_TYPE_VLAN);

    // tagged frames carry the real type after the tag
    assign eff_type = vlan ? fields.inner_type : fields.eth_type;
    assign ipv4     = (eff_type == parser_pkg::ETH_TYPE_IPV4);

    assign flags.vlan = vlan;
    assign flags.arp  = (eff_type == parser_pkg::ETH_TYPE_ARP);
    assign flags.ipv4 = ipv4;
    assign flags.tcp  = ipv4 && (fields.ip_proto == parser_pkg::IP_PROTO_TCP);
    assign flags.udp  = ipv4 && (fields.ip_proto == parser_pkg::IP_PROTO_UDP);

    assign l4 = flags.tcp || flags.udp;

    always_comb begin
        if (!l4) begin
            pkt_type = parser_pkg::PT_NONE;
        end else if (vlan) begin
            pkt_type = parser_pkg::PT_VLV4;
        end else begin
            pkt_type = parser_pkg::PT_IPV4;
        end
    end

endmodule

/* source/eth_parser.sv */
// 8 byte beats only; fields are levels, valid with the last output beat and held until next frame
`timescale 1ns/1ps

module eth_parser (
    input  logic                     clk,
    input  logic                     rst,
    input  parser_pkg::beat_t        s_beat,
    input  logic                     s_valid,
    output logic                     s_ready,
    output parser_pkg::beat_t        m_beat,
    output logic                     m_valid,
    input  logic                     m_ready,
    output parser_pkg::hdr_fields_t  fields,
    output parser_pkg::parse_flags_t flags,
    output parser_pkg::pkt_type_t    pkt_type
);

    logic                  accept;
    parser_pkg::beat_idx_t beat_idx;
    logic                  l4;

    // decode feedback for later beats, all from registers
    assign l4 = flags.tcp || flags.udp;

    stream_stage stream_stage_i (
        .clk      (clk),
        .rst      (rst),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .accept   (accept),
        .beat_idx (beat_idx)
    );

    header_capture header_capture_i (
        .clk      (clk),
        .rst      (rst),
        .accept   (accept),
        .beat     (s_beat),
        .beat_idx (beat_idx),
        .vlan     (flags.vlan),
        .ipv4     (flags.ipv4),
        .l4       (l4),
        .fields   (fields)
    );

    frame_classifier frame_classifier_i (
        .fields   (fields),
        .flags    (flags),
        .pkt_type (pkt_type)
    );

endmodule

/* test/clock_gen.sv */
// free running 10 ns clock from time 0; rst high for 16 rising edges, dropped on a falling edge
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 5;
    localparam int RESET_CYCLES = 16;

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* test/eth_parser_tb.sv */
// directed tests with frames of 6 beats or more; payload bytes depend on seed 4 and the call order
`timescale 1ns/1ps

module eth_parser_tb;

    typedef byte unsigned bytes_t[$];

    localparam int TIMEOUT = 200;

    logic                     clk;
    logic                     rst;
    parser_pkg::beat_t        s_beat;
    logic                     s_valid;
    logic                     s_ready;
    parser_pkg::beat_t        m_beat;
    logic                     m_valid;
    logic                     m_ready;
    parser_pkg::hdr_fields_t  fields;
    parser_pkg::parse_flags_t flags;
    parser_pkg::pkt_type_t    pkt_type;

    // expected traffic of the running test
    parser_pkg::beat_t        exp_beats[$];
    parser_pkg::hdr_fields_t  exp_fields[$];
    parser_pkg::parse_flags_t exp_flags[$];
    parser_pkg::pkt_type_t    exp_types[$];

    clock_gen clock_gen_i (
        .clk (clk),
        .rst (rst)
    );

    eth_parser eth_parser_i (
        .clk      (clk),
        .rst      (rst),
        .s_beat   (s_beat),
        .s_valid  (s_valid),
        .s_ready  (s_ready),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready),
        .fields   (fields),
        .flags    (flags),
        .pkt_type (pkt_type)
    );

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got == exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // big-endian read, bytes past the end count as zero
    function automatic logic [63:0] read_be(input bytes_t frm, input int off, input int len);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < len; i++) begin
            val = {val[55:0], (off + i < frm.size()) ? frm[off + i] : 8'h00};
        end
        return val;
    endfunction

    // reference model on the raw frame bytes
    task automatic model_frame(input bytes_t frm, output parser_pkg::hdr_fields_t f,
                               output parser_pkg::parse_flags_t fl,
                               output parser_pkg::pkt_type_t pt);
        int          sh;
        logic [15:0] eff;
        f  = '0;
        fl = '0;
        sh = 0;
        f.dst_mac  = 48'(read_be(frm, 0, 6));
        f.src_mac  = 48'(read_be(frm, 6, 6));
        f.eth_type = 16'(read_be(frm, 12, 2));
        eff        = f.eth_type;
        fl.vlan    = (f.eth_type == 16'h8100);
        if (fl.vlan) begin
            // tag in bytes 12 to 15, real type right after it
            sh           = 4;
            f.inner_type = 16'(read_be(frm, 16, 2));
            eff          = f.inner_type;
        end
        fl.arp  = (eff == 16'h0806);
        fl.ipv4 = (eff == 16'h0800);
        if (fl.ipv4) begin
            f.ip_proto = 8'(read_be(frm, 23 + sh, 1));
            f.src_ip   = 32'(read_be(frm, 26 + sh, 4));
            f.dst_ip   = 32'(read_be(frm, 30 + sh, 4));
            fl.tcp     = (f.ip_proto == 8'd6);
            fl.udp     = (f.ip_proto == 8'd17);
        end
        pt = parser_pkg::PT_NONE;
        if (fl.tcp || fl.udp) begin
            f.src_port = 16'(read_be(frm, 34 + sh, 2));
            f.dst_port = 16'(read_be(frm, 36 + sh, 2));
            pt         = fl.vlan ? parser_pkg::PT_VLV4 : parser_pkg::PT_IPV4;
        end
    endtask

    task automatic build_frame(output bytes_t frm, input bit has_tag, input logic [15:0] etype,
                               input logic [7:0] proto, input int len);
        int sh;
        frm = {};
        sh  = has_tag ? 4 : 0;
        for (int i = 0; i < len; i++) begin
            frm.push_back(8'($urandom));
        end
        if (has_tag) begin
            frm[12] = 8'h81;
            frm[13] = 8'h00;
        end
        frm[12 + sh] = etype[15:8];
        frm[13 + sh] = etype[7:0];
        if (etype == 16'h0800) begin
            // version 4, 20 byte header
            frm[14 + sh] = 8'h45;
            frm[23 + sh] = proto;
        end
    endtask

    task automatic queue_frame(input bytes_t frm);
        parser_pkg::beat_t        b;
        parser_pkg::hdr_fields_t  f;
        parser_pkg::parse_flags_t fl;
        parser_pkg::pkt_type_t    pt;
        int                       nbeats;
        nbeats = (frm.size() + 7) / 8;
        for (int k = 0; k < nbeats; k++) begin
            b = '0;
            for (int lane = 0; lane < 8; lane++) begin
                if (8 * k + lane < frm.size()) begin
                    b.data[8 * lane +: 8] = frm[8 * k + lane];
                    b.keep[lane]          = 1'b1;
                end
            end
            b.last = (k == nbeats - 1);
            exp_beats.push_back(b);
        end
        model_frame(frm, f, fl, pt);
        exp_fields.push_back(f);
        exp_flags.push_back(fl);
        exp_types.push_back(pt);
    endtask

    task automatic check_fields(input int idx);
        check_value("fields.dst_mac", 64'(fields.dst_mac), 64'(exp_fields[idx].dst_mac));
        check_value("fields.src_mac", 64'(fields.src_mac), 64'(exp_fields[idx].src_mac));
        check_value("fields.eth_type", 64'(fields.eth_type), 64'(exp_fields[idx].eth_type));
        check_value("fields.inner_type", 64'(fields.inner_type),
                    64'(exp_fields[idx].inner_type));
        // protocol byte only has a meaning for ipv4
        if (exp_flags[idx].ipv4) begin
            check_value("fields.ip_proto", 64'(fields.ip_proto), 64'(exp_fields[idx].ip_proto));
        end
        check_value("fields.src_ip", 64'(fields.src_ip), 64'(exp_fields[idx].src_ip));
        check_value("fields.dst_ip", 64'(fields.dst_ip), 64'(exp_fields[idx].dst_ip));
        check_value("fields.src_port", 64'(fields.src_port), 64'(exp_fields[idx].src_port));
        check_value("fields.dst_port", 64'(fields.dst_port), 64'(exp_fields[idx].dst_port));
        check_value("flags", 64'(flags), 64'(exp_flags[idx]));
        check_value("pkt_type", 64'(pkt_type), 64'(exp_types[idx]));
    endtask

    task automatic send_beats();
        int wait_cycles;
        for (int n = 0; n < exp_beats.size(); n++) begin
            @(negedge clk);
            s_valid = 1'b1;
            s_beat  = exp_beats[n];
            #1;
            wait_cycles = 0;
            while (!s_ready) begin
                wait_cycles++;
                if (wait_cycles > TIMEOUT) begin
                    $display("input beat %0d was not accepted within %0d cycles", n, TIMEOUT);
                    abort_run();
                end
                @(negedge clk);
                #1;
            end
        end
        @(negedge clk);
        s_valid = 1'b0;
        s_beat  = '0;
    endtask

    task automatic collect_beats(input bit bp);
        int n;
        int frame;
        int idle;
        n     = 0;
        frame = 0;
        idle  = 0;
        while (n < exp_beats.size()) begin
            @(negedge clk);
            m_ready = bp ? 1'($urandom_range(0, 1)) : 1'b1;
            #1;
            // a stalled output must hold off the source
            if (m_valid && !m_ready) begin
                assert (!s_ready) else begin
                    $display("s_ready is high while the output is stalled at %0t", $time);
                    abort_run();
                end
            end
            if (m_valid && m_ready) begin
                check_value("m_beat.data", m_beat.data, exp_beats[n].data);
                check_value("m_beat.keep", 64'(m_beat.keep), 64'(exp_beats[n].keep));
                check_value("m_beat.last", 64'(m_beat.last), 64'(exp_beats[n].last));
                if (m_beat.last) begin
                    check_fields(frame);
                    frame++;
                end
                n++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    $display("no output beat arrived for %0d cycles", TIMEOUT);
                    abort_run();
                end
            end
        end
        check_value("frames seen", 64'(frame), 64'(exp_fields.size()));
    endtask

    task automatic run_traffic(input bit bp);
        fork
            send_beats();
            collect_beats(bp);
        join
        exp_beats.delete();
        exp_fields.delete();
        exp_flags.delete();
        exp_types.delete();
    endtask

    task automatic test_reset_state();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("reset was not released within %0d cycles", TIMEOUT);
                abort_run();
            end
        end while (rst !== 1'b0);
        check_value("s_ready", 64'(s_ready), 64'd1);
        check_value("m_valid", 64'(m_valid), 64'd0);
        check_value("flags", 64'(flags), 64'd0);
        check_value("pkt_type", 64'(pkt_type), 64'(parser_pkg::PT_NONE));
        assert (fields == '0) else begin
            $display("ERROR at %0t: fields is %h, expected 0", $time, fields);
            abort_run();
        end
    endtask

    task automatic test_ipv4_tcp();
        bytes_t frm;
        // 60 bytes, last beat half full
        build_frame(frm, 1'b0, 16'h0800, 8'd6, 60);
        queue_frame(frm);
        run_traffic(1'b0);
        check_value("flags.ipv4", 64'(flags.ipv4), 64'd1);
        check_value("flags.tcp", 64'(flags.tcp), 64'd1);
        check_value("pkt_type", 64'(pkt_type), 64'(parser_pkg::PT_IPV4));
    endtask

    task automatic test_vlan_udp();
        bytes_t frm;
        build_frame(frm, 1'b1, 16'h0800, 8'd17, 68);
        queue_frame(frm);
        run_traffic(1'b0);
        check_value("flags.vlan", 64'(flags.vlan), 64'd1);
        check_value("flags.udp", 64'(flags.udp), 64'd1);
        check_value("pkt_type", 64'(pkt_type), 64'(parser_pkg::PT_VLV4));
    endtask

    task automatic test_arp_then_ipv4();
        bytes_t frm;
        // tagged, so its inner type must not leak into the next frame
        build_frame(frm, 1'b1, 16'h0806, 8'd0, 48);
        queue_frame(frm);
        run_traffic(1'b0);
        check_value("flags.arp", 64'(flags.arp), 64'd1);
        check_value("fields.src_ip", 64'(fields.src_ip), 64'd0);
        check_value("pkt_type", 64'(pkt_type), 64'(parser_pkg::PT_NONE));
        // icmp, so no ports
        build_frame(frm, 1'b0, 16'h0800, 8'd1, 56);
        queue_frame(frm);
        run_traffic(1'b0);
        check_value("flags.arp", 64'(flags.arp), 64'd0);
        check_value("flags.ipv4", 64'(flags.ipv4), 64'd1);
        check_value("fields.src_port", 64'(fields.src_port), 64'd0);
        check_value("pkt_type", 64'(pkt_type), 64'(parser_pkg::PT_NONE));
    endtask

    task automatic test_backpressure();
        bytes_t frm;
        build_frame(frm, 1'b0, 16'h0800, 8'd6, 60);
        queue_frame(frm);
        build_frame(frm, 1'b1, 16'h0800, 8'd17, 72);
        queue_frame(frm);
        build_frame(frm, 1'b1, 16'h0806, 8'd0, 50);
        queue_frame(frm);
        build_frame(frm, 1'b0, 16'h0800, 8'd17, 64);
        queue_frame(frm);
        run_traffic(1'b1);
    endtask

    initial begin
        s_beat  = '0;
        s_valid = 1'b0;
        m_ready = 1'b1;
        void'($urandom(4));
        test_reset_state();
        test_ipv4_tcp();
        test_vlan_udp();
        test_arp_then_ipv4();
        test_backpressure();
        $display(">>> PASS");
        $finish;
    end

endmodule

/* sources.f */
source/parser_pkg.sv
source/stream_stage.sv
source/header_capture.sv
source/frame_classifier.sv
source/eth_parser.sv
test/clock_gen.sv
test/eth_parser_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module eth_parser_tb -f sources.f \
    -o eth_parser_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/eth_parser_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log || exit 1
exit 0
